//--- build.f
common/tmu_pkg.sv
control/tmu_ctlif.sv
logic/tmu_clamp.sv
logic/tmu_adrgen.sv
logic/tmu_decay.sv
writeback/tmu_burst.sv
writeback/tmu_pixout.sv
logic/tmu_top.sv
testbench/tmu_tb_checks.sv
testbench/tmu_tb.sv

//--- testbench/tmu_tb.sv
// texture mapping unit testbench

module tmu_tb import tmu_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          FRAG_TOTAL = 62;
	localparam int          CLK_NS     = 40;
	localparam logic [15:0] KEY_COLOR  = 16'hf81f;

	logic                      sys_clk = 1'b0;
	logic                      sys_rst;
	logic [3:0]                csr_a_i;
	logic                      csr_we_i;
	logic [31:0]               csr_di_i;
	logic [31:0]               csr_do_o;
	logic                      irq_o;
	logic                      frag_stb_i;
	logic                      frag_last_i;
	logic signed [COORD_W-1:0] frag_x_i;
	logic signed [COORD_W-1:0] frag_y_i;
	pixel_t                    frag_color_i;
	logic                      frag_ack_o;
	logic [MEM_ADR_W-1:0]      fmlw_adr_o;
	logic                      fmlw_stb_o;
	logic [7:0]                fmlw_sel_o;
	logic [63:0]               fmlw_do_o;
	logic                      fmlw_ack_i;

	logic [31:0] lfsr_state = 32'hd764_80f5;
	logic        stall_mode = 1'b0;
	int          ack_cnt = 0;
	int          stall_cycles = 0; // cycles the fragment port waited
	int          tb_errors = 0;
	int          tests_done = 0;

	tmu_top u_tmu_top (.*);
	tmu_tb_checks u_checks (.*);

	always #(CLK_NS / 2) sys_clk = ~sys_clk;

	// memory side acknowledges two cycles of three, or one in 64 when stalled
	always @(posedge sys_clk) begin
		#2;
		ack_cnt = ack_cnt + 1;
		if (stall_mode)
			fmlw_ack_i = (ack_cnt % 64) == 0;
		else
			fmlw_ack_i = (ack_cnt % 3) != 0;
	end

	initial begin
		#((FRAG_TOTAL * 200 + 2000) * CLK_NS);
		$display("watchdog expired before all tests finished");
		$display("Result: FAILED");
		$finish;
	end

	// ========================================
	// helpers
	// ========================================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic csr_write(input logic [3:0] a, input logic [31:0] d);
		csr_a_i  = a;
		csr_di_i = d;
		csr_we_i = 1'b1;
		@(posedge sys_clk);
		#2;
		csr_we_i = 1'b0;
	endtask

	task automatic csr_read(input logic [3:0] a, output logic [31:0] d);
		csr_a_i = a;
		@(posedge sys_clk);
		#2;
		d = csr_do_o; // registered read data
	endtask

	task automatic send_frag(input int x, input int y, input logic [15:0] c, input logic last);
		frag_stb_i   = 1'b1;
		frag_last_i  = last;
		frag_x_i     = COORD_W'(x);
		frag_y_i     = COORD_W'(y);
		frag_color_i = c;
		@(posedge sys_clk);
		while (!frag_ack_o) begin
			stall_cycles++;
			@(posedge sys_clk);
		end
		#2;
		frag_stb_i  = 1'b0;
		frag_last_i = 1'b0;
	endtask

	// every second color is the key when key_mix is nonzero
	task automatic send_random(input int n, input int xbits, input int ybits, input int bias,
		input logic [15:0] key_mix);
		logic [31:0] x;
		logic [31:0] y;
		logic [31:0] c;
		for (int i = 0; i < n; i++) begin
			take_bits(xbits, x);
			take_bits(ybits, y);
			take_bits(16, c);
			if (key_mix != 0 && i % 2 == 1)
				c = key_mix;
			send_frag(int'(x) - bias, int'(y) - bias, c[15:0], i == n - 1);
		end
	endtask

	task automatic finish_run(input string name);
		logic [31:0] rd;
		while (!irq_o) begin
			@(posedge sys_clk);
			#2;
		end
		csr_read(CSR_CTRL, rd);
		assert (!rd[0] && rd[2])
		else begin
			tb_errors++;
			$display("CTRL read after irq_o does not show idle with irq set");
		end
		csr_write(CSR_CTRL, 32'd0); // clears irq
		assert (!irq_o)
		else begin
			tb_errors++;
			$display("irq_o still high after a CTRL write");
		end
		tests_done++;
		$display("test %0d %s finished, %0d errors so far", tests_done, name,
			tb_errors + u_checks.error_count);
	endtask

	// ========================================
	// test sequence
	// ========================================
	initial begin
		logic [31:0] rd;
		int          stall_start;
		sys_rst      = 1'b1;
		csr_a_i      = '0;
		csr_we_i     = 1'b0;
		csr_di_i     = '0;
		frag_stb_i   = 1'b0;
		frag_last_i  = 1'b0;
		frag_x_i     = '0;
		frag_y_i     = '0;
		frag_color_i = '0;
		fmlw_ack_i   = 1'b0;
		repeat (16) @(posedge sys_clk);
		#2;
		sys_rst = 1'b0;
		assert (!irq_o && !fmlw_stb_o && !frag_ack_o)
		else begin
			tb_errors++;
			$display("irq_o, fmlw_stb_o or frag_ack_o high after reset");
		end

		csr_write(CSR_FBUF, 32'h0001_0000);
		csr_write(CSR_HRES, 32'd64);
		csr_write(CSR_VRES, 32'd48);
		csr_write(CSR_BRIGHT, 32'd63); // full brightness leaves colors as they are
		csr_write(CSR_HOFS, 32'd0);
		csr_write(CSR_VOFS, 32'd0);
		csr_write(CSR_CTRL, 32'd1);
		csr_read(CSR_CTRL, rd);
		assert (rd[0])
		else begin
			tb_errors++;
			$display("CTRL read shows idle during a run");
		end
		for (int i = 0; i < 4; i++)
			send_frag(i, 5, 16'h1111 * (i + 1), 1'b0); // one full word
		send_random(12, 6, 5, 0, 16'h0);
		finish_run("full and random words");

		csr_write(CSR_HOFS, 32'hffff_fffb); // minus five
		csr_write(CSR_VOFS, 32'd3);
		csr_write(CSR_CTRL, 32'd1);
		send_frag(2, 0, 16'h0f0f, 1'b0);   // x lands at -3
		send_frag(69, 0, 16'hf0f0, 1'b0);  // x lands at 64
		send_frag(10, 45, 16'h3c3c, 1'b0); // y lands at 48
		send_frag(10, -3, 16'h0ff0, 1'b0);
		send_random(12, 7, 6, 8, 16'h0);
		finish_run("off-screen filtering");

		csr_write(CSR_HOFS, 32'd0);
		csr_write(CSR_VOFS, 32'd0);
		csr_write(CSR_BRIGHT, 32'd20);
		csr_write(CSR_KEY, 32'(KEY_COLOR));
		csr_write(CSR_CTRL, 32'd3); // start with the key enabled
		send_random(16, 6, 5, 0, KEY_COLOR);
		finish_run("chroma key and decay");

		csr_write(CSR_BRIGHT, 32'd63);
		csr_write(CSR_CTRL, 32'd1);
		send_frag(8, 2, 16'habcd, 1'b0);
		send_frag(9, 2, 16'h1234, 1'b1);
		finish_run("partial word flush");

		stall_mode  = 1'b1;
		stall_start = stall_cycles;
		csr_write(CSR_CTRL, 32'd1);
		for (int i = 0; i < 12; i++)
			send_frag(i * 4, 7, 16'h0101 * (i + 1), i == 11); // one word each
		assert (stall_cycles - stall_start > 16)
		else begin
			tb_errors++;
			$display("fragment port never stalled while memory held off");
		end
		finish_run("memory back-pressure");
		stall_mode = 1'b0;

		$display("%0d tests run, %0d checks failed", tests_done, tb_errors + u_checks.error_count);
		if (tb_errors + u_checks.error_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- testbench/tmu_tb_checks.sv
// expected write model and checks

module tmu_tb_checks import tmu_pkg::*; (
	input logic                      sys_clk,
	input logic                      sys_rst,
	input logic [3:0]                csr_a_i,
	input logic                      csr_we_i,
	input logic [31:0]               csr_di_i,
	input logic                      irq_o,
	input logic                      frag_stb_i,
	input logic                      frag_last_i,
	input logic signed [COORD_W-1:0] frag_x_i,
	input logic signed [COORD_W-1:0] frag_y_i,
	input pixel_t                    frag_color_i,
	input logic                      frag_ack_o,
	input logic [MEM_ADR_W-1:0]      fmlw_adr_o,
	input logic                      fmlw_stb_o,
	input logic [7:0]                fmlw_sel_o,
	input logic [63:0]               fmlw_do_o,
	input logic                      fmlw_ack_i
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [BRIGHT_W-1:0]       bright;
	logic                      key_en;
	logic [15:0]               key;
	logic [PIX_ADR_W-1:0]      fbuf;
	logic [RES_W-1:0]          hres;
	logic [RES_W-1:0]          vres;
	logic signed [COORD_W-1:0] hofs;
	logic signed [COORD_W-1:0] vofs;
	logic [WORD_ADR_W-1:0]     open_adr; // word being assembled in the model
	logic [7:0]                open_sel;
	logic [63:0]               open_data;
	logic [WORD_ADR_W+71:0]    exp_q[$]; // {word address, select, data}
	logic                      head_valid;
	logic [WORD_ADR_W-1:0]     head_adr;
	logic [7:0]                head_sel;
	logic [63:0]               head_data;
	int                        error_count = 0;

	function automatic logic [63:0] byte_mask(input logic [7:0] sel);
		logic [63:0] m;
		for (int i = 0; i < 8; i++)
			m[i*8 +: 8] = {8{sel[i]}};
		return m;
	endfunction

	task automatic close_word();
		if (open_sel != 0)
			exp_q.push_back({open_adr, open_sel, open_data});
		open_sel  = '0;
		open_data = '0;
	endtask

	task automatic model_fragment(input logic signed [COORD_W-1:0] fx,
		input logic signed [COORD_W-1:0] fy, input logic [15:0] c);
		int                   px;
		int                   py;
		int                   r;
		int                   g;
		int                   b;
		int                   lane;
		logic [PIX_ADR_W-1:0] adr;
		px = int'(fx) + int'(hofs);
		py = int'(fy) + int'(vofs);
		if (px < 0 || py < 0 || px >= int'(hres) || py >= int'(vres))
			return; // off screen
		if (key_en && c == key)
			return;
		adr = fbuf + PIX_ADR_W'(py * int'(hres) + px);
		r = (int'(c[15:11]) * (int'(bright) + 1)) >> 6;
		g = (int'(c[10:5]) * (int'(bright) + 1)) >> 6;
		b = (int'(c[4:0]) * (int'(bright) + 1)) >> 6;
		lane = adr[1:0];
		if (open_sel != 0 && open_adr != adr[PIX_ADR_W-1:2])
			close_word();
		open_adr = adr[PIX_ADR_W-1:2];
		open_sel[lane*2 +: 2] = 2'b11;
		open_data[lane*16 +: 16] = {r[4:0], g[5:0], b[4:0]};
	endtask

	// ========================================
	// model, fed from the DUT ports
	// ========================================
	always @(posedge sys_clk) begin
		if (sys_rst) begin
			bright   = '1;
			key_en   = 1'b0;
			key      = '0;
			fbuf     = '0;
			hres     = '0;
			vres     = '0;
			hofs     = '0;
			vofs     = '0;
			open_sel = '0;
			exp_q.delete();
		end else begin
			if (csr_we_i) begin
				case (csr_a_i)
					CSR_CTRL:   key_en = csr_di_i[1];
					CSR_BRIGHT: bright = csr_di_i[BRIGHT_W-1:0];
					CSR_KEY:    key    = csr_di_i[15:0];
					CSR_FBUF:   fbuf   = csr_di_i[PIX_ADR_W-1:0];
					CSR_HRES:   hres   = csr_di_i[RES_W-1:0];
					CSR_VRES:   vres   = csr_di_i[RES_W-1:0];
					CSR_HOFS:   hofs   = csr_di_i[COORD_W-1:0];
					CSR_VOFS:   vofs   = csr_di_i[COORD_W-1:0];
					default: ;
				endcase
			end
			if (frag_stb_i && frag_ack_o) begin
				model_fragment(frag_x_i, frag_y_i, frag_color_i.raw);
				if (frag_last_i)
					close_word(); // the run ends with a flush
			end
			if (fmlw_stb_o && fmlw_ack_i && exp_q.size() > 0)
				void'(exp_q.pop_front());
		end
		head_valid = exp_q.size() > 0;
		if (head_valid)
			{head_adr, head_sel, head_data} = exp_q[0];
	end

	a_expected: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fmlw_stb_o && fmlw_ack_i |-> head_valid)
		else begin
			error_count++;
			$display("memory write of a word that should not have been written");
		end

	a_adr: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fmlw_stb_o && fmlw_ack_i && head_valid |-> fmlw_adr_o == {head_adr, 3'b000})
		else begin
			error_count++;
			$display("Mismatch fmlw_adr_o: got %h, expected %h", $sampled(fmlw_adr_o),
				{$sampled(head_adr), 3'b000});
		end

	a_sel: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fmlw_stb_o && fmlw_ack_i && head_valid |-> fmlw_sel_o == head_sel)
		else begin
			error_count++;
			$display("Mismatch fmlw_sel_o: got %h, expected %h", $sampled(fmlw_sel_o),
				$sampled(head_sel));
		end

	// bytes outside the select carry nothing
	a_data: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fmlw_stb_o && fmlw_ack_i && head_valid |->
		(fmlw_do_o & byte_mask(head_sel)) == (head_data & byte_mask(head_sel)))
		else begin
			error_count++;
			$display("Mismatch fmlw_do_o: got %h, expected %h",
				$sampled(fmlw_do_o) & byte_mask($sampled(head_sel)),
				$sampled(head_data) & byte_mask($sampled(head_sel)));
		end

	a_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fmlw_stb_o && !fmlw_ack_i |=> fmlw_stb_o && $stable(fmlw_adr_o)
		&& $stable(fmlw_sel_o) && $stable(fmlw_do_o))
		else begin
			error_count++;
			$display("memory write request dropped or changed before its acknowledge");
		end

	a_drained: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$rose(irq_o) |-> !head_valid)
		else begin
			error_count++;
			$display("irq_o rose while expected words were still not written");
		end

endmodule

//--- logic/tmu_top.sv
// texture mapping unit pixel back end

module tmu_top import tmu_pkg::*; (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  logic [3:0]                csr_a_i,
	input  logic                      csr_we_i,
	input  logic [31:0]               csr_di_i,
	output logic [31:0]               csr_do_o,
	output logic                      irq_o,
	input  logic                      frag_stb_i,
	input  logic                      frag_last_i,
	input  logic signed [COORD_W-1:0] frag_x_i,
	input  logic signed [COORD_W-1:0] frag_y_i,
	input  pixel_t                    frag_color_i,
	output logic                      frag_ack_o,
	output logic [MEM_ADR_W-1:0]      fmlw_adr_o,
	output logic                      fmlw_stb_o,
	output logic [7:0]                fmlw_sel_o,
	output logic [63:0]               fmlw_do_o,
	input  logic                      fmlw_ack_i
);

	logic                      flush;
	logic [BRIGHT_W-1:0]       brightness;
	logic                      chroma_key_en;
	pixel_t                    chroma_key;
	logic [PIX_ADR_W-1:0]      dst_fbuf;
	logic [RES_W-1:0]          dst_hres, dst_vres;
	logic signed [COORD_W-1:0] dst_hoffset, dst_voffset;

	logic ctl_stb, ctl_ack, clamp_stb, clamp_ack, adrgen_stb, adrgen_ack;
	logic decay_stb, decay_ack, burst_stb, burst_ack;
	logic clamp_busy, adrgen_busy, decay_busy, burst_busy, pixout_busy;

	logic [RES_W-1:0]      clamp_x, clamp_y;
	pixel_t                clamp_color, adrgen_color, decay_color;
	logic [PIX_ADR_W-1:0]  adrgen_dadr, decay_dadr;
	logic [WORD_ADR_W-1:0] burst_adr;
	logic [7:0]            burst_sel;
	logic [63:0]           burst_data;

	tmu_ctlif u_ctlif (.sys_clk, .sys_rst, .csr_a_i, .csr_we_i, .csr_di_i, .csr_do_o, .irq_o,
		.frag_stb_i, .frag_last_i, .frag_ack_o, .pipe_stb_o(ctl_stb), .pipe_ack_i(ctl_ack),
		.clamp_busy_i(clamp_busy), .adrgen_busy_i(adrgen_busy), .decay_busy_i(decay_busy),
		.burst_busy_i(burst_busy), .pixout_busy_i(pixout_busy), .flush_o(flush),
		.brightness_o(brightness), .chroma_key_en_o(chroma_key_en), .chroma_key_o(chroma_key),
		.dst_fbuf_o(dst_fbuf), .dst_hres_o(dst_hres), .dst_vres_o(dst_vres),
		.dst_hoffset_o(dst_hoffset), .dst_voffset_o(dst_voffset));

	tmu_clamp u_clamp (.sys_clk, .sys_rst, .pipe_stb_i(ctl_stb), .pipe_ack_o(ctl_ack),
		.x_i(frag_x_i), .y_i(frag_y_i), .color_i(frag_color_i), .dst_hoffset_i(dst_hoffset),
		.dst_voffset_i(dst_voffset), .dst_hres_i(dst_hres), .dst_vres_i(dst_vres),
		.pipe_stb_o(clamp_stb), .pipe_ack_i(clamp_ack), .x_o(clamp_x), .y_o(clamp_y),
		.color_o(clamp_color), .busy_o(clamp_busy));

	tmu_adrgen u_adrgen (.sys_clk, .sys_rst, .pipe_stb_i(clamp_stb), .pipe_ack_o(clamp_ack),
		.x_i(clamp_x), .y_i(clamp_y), .color_i(clamp_color), .dst_fbuf_i(dst_fbuf),
		.dst_hres_i(dst_hres), .pipe_stb_o(adrgen_stb), .pipe_ack_i(adrgen_ack),
		.dadr_o(adrgen_dadr), .color_o(adrgen_color), .busy_o(adrgen_busy));

	tmu_decay u_decay (.sys_clk, .sys_rst, .pipe_stb_i(adrgen_stb), .pipe_ack_o(adrgen_ack),
		.dadr_i(adrgen_dadr), .color_i(adrgen_color), .brightness_i(brightness),
		.chroma_key_en_i(chroma_key_en), .chroma_key_i(chroma_key), .pipe_stb_o(decay_stb),
		.pipe_ack_i(decay_ack), .dadr_o(decay_dadr), .color_o(decay_color),
		.busy_o(decay_busy));

	tmu_burst u_burst (.sys_clk, .sys_rst, .flush_i(flush), .pipe_stb_i(decay_stb),
		.pipe_ack_o(decay_ack), .dadr_i(decay_dadr), .color_i(decay_color),
		.pipe_stb_o(burst_stb), .pipe_ack_i(burst_ack), .word_adr_o(burst_adr),
		.sel_o(burst_sel), .data_o(burst_data), .busy_o(burst_busy));

	tmu_pixout u_pixout (.sys_clk, .sys_rst, .pipe_stb_i(burst_stb), .pipe_ack_o(burst_ack),
		.word_adr_i(burst_adr), .sel_i(burst_sel), .data_i(burst_data), .fmlw_adr_o,
		.fmlw_stb_o, .fmlw_ack_i, .fmlw_sel_o, .fmlw_do_o, .busy_o(pixout_busy));

endmodule

//--- writeback/tmu_pixout.sv
// memory write port

module tmu_pixout import tmu_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  logic                  pipe_stb_i,
	output logic                  pipe_ack_o,
	input  logic [WORD_ADR_W-1:0] word_adr_i,
	input  logic [7:0]            sel_i,
	input  logic [63:0]           data_i,
	output logic [MEM_ADR_W-1:0]  fmlw_adr_o,
	output logic                  fmlw_stb_o,
	input  logic                  fmlw_ack_i,
	output logic [7:0]            fmlw_sel_o,
	output logic [63:0]           fmlw_do_o,
	output logic                  busy_o
);

	assign pipe_ack_o = !fmlw_stb_o || fmlw_ack_i;
	assign busy_o     = fmlw_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			fmlw_stb_o <= 1'b0;
		else if (pipe_ack_o)
			fmlw_stb_o <= pipe_stb_i;
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i && pipe_ack_o) begin
			fmlw_adr_o <= {word_adr_i, 3'b000}; // byte address of the 64-bit word
			fmlw_sel_o <= sel_i;
			fmlw_do_o  <= data_i;
		end
	end

	a_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fmlw_stb_o && !fmlw_ack_i |=> fmlw_stb_o && $stable(fmlw_adr_o)
		&& $stable(fmlw_sel_o) && $stable(fmlw_do_o))
		else $error("write request changed before acknowledge");

endmodule

//--- writeback/tmu_burst.sv
// pixel to 64-bit word assembler

module tmu_burst import tmu_pkg::*; (
	input  logic                    sys_clk,
	input  logic                    sys_rst,
	input  logic                    flush_i,
	input  logic                    pipe_stb_i,
	output logic                    pipe_ack_o,
	input  logic [PIX_ADR_W-1:0]    dadr_i,
	input  pixel_t                  color_i,
	output logic                    pipe_stb_o,
	input  logic                    pipe_ack_i,
	output logic [WORD_ADR_W-1:0]   word_adr_o,
	output logic [2*PIX_PER_WORD-1:0] sel_o,
	output logic [63:0]             data_o,
	output logic                    busy_o
);

	logic [WORD_ADR_W-1:0]     acc_adr;  // word being assembled
	logic [2*PIX_PER_WORD-1:0] acc_sel;  // nonzero while a word is open
	logic [63:0]               acc_data;
	logic                      flush_pend;
	logic [WORD_ADR_W-1:0]     in_word;
	logic [LANE_W-1:0]         in_lane;
	logic [2*PIX_PER_WORD-1:0] lane_sel;
	logic [63:0]               lane_mask;
	logic [63:0]               lane_data;
	logic                      acc_used;
	logic                      fresh;
	logic                      in_xfer;
	logic                      emit;

	assign in_word   = dadr_i[PIX_ADR_W-1:LANE_W];
	assign in_lane   = dadr_i[LANE_W-1:0];
	assign lane_sel  = 8'b11 << (in_lane * 2);        // lane 0 sits in the low bytes
	assign lane_mask = 64'hffff << (in_lane * 16);
	assign lane_data = 64'(color_i.raw) << (in_lane * 16);
	assign acc_used  = |acc_sel;
	assign fresh     = !acc_used || (acc_adr != in_word);

	assign pipe_ack_o = !pipe_stb_o || pipe_ack_i;
	assign in_xfer    = pipe_stb_i && pipe_ack_o;
	// a pixel for another word pushes the open one out, otherwise a flush does
	assign emit = acc_used && ((in_xfer && acc_adr != in_word) || (flush_pend && !in_xfer && pipe_ack_o));
	assign busy_o = pipe_stb_o || acc_used || flush_pend;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pipe_stb_o <= 1'b0;
			acc_sel    <= '0;
			flush_pend <= 1'b0;
		end else begin
			if (pipe_ack_o)
				pipe_stb_o <= emit;
			if (flush_i)
				flush_pend <= 1'b1;
			else if (flush_pend && !in_xfer && pipe_ack_o)
				flush_pend <= 1'b0;
			if (in_xfer)
				acc_sel <= fresh ? lane_sel : (acc_sel | lane_sel);
			else if (emit)
				acc_sel <= '0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (emit) begin
			word_adr_o <= acc_adr;
			sel_o      <= acc_sel;
			data_o     <= acc_data;
		end
		if (in_xfer) begin
			acc_adr  <= in_word;
			acc_data <= fresh ? lane_data : ((acc_data & ~lane_mask) | lane_data);
		end
	end

	// an emitted word always carries at least one pixel
	a_sel_nonzero: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o |-> |sel_o)
		else $error("burst word offered with no byte selected");

endmodule

//--- logic/tmu_decay.sv
// brightness decay and chroma key filter

module tmu_decay import tmu_pkg::*; (
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  logic                 pipe_stb_i,
	output logic                 pipe_ack_o,
	input  logic [PIX_ADR_W-1:0] dadr_i,
	input  pixel_t               color_i,
	input  logic [BRIGHT_W-1:0]  brightness_i,
	input  logic                 chroma_key_en_i,
	input  pixel_t               chroma_key_i,
	output logic                 pipe_stb_o,
	input  logic                 pipe_ack_i,
	output logic [PIX_ADR_W-1:0] dadr_o,
	output pixel_t               color_o,
	output logic                 busy_o
);

	logic [BRIGHT_W:0]   mult; // brightness plus one, 64 means full scale
	logic [BRIGHT_W+5:0] r_prod;
	logic [BRIGHT_W+6:0] g_prod;
	logic [BRIGHT_W+5:0] b_prod;
	logic                keyed;

	assign mult   = {1'b0, brightness_i} + 1'b1;
	assign r_prod = color_i.rgb.r * mult;
	assign g_prod = color_i.rgb.g * mult;
	assign b_prod = color_i.rgb.b * mult;

	assign keyed = chroma_key_en_i && (color_i.raw == chroma_key_i.raw);

	assign pipe_ack_o = !pipe_stb_o || pipe_ack_i;
	assign busy_o     = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pipe_stb_o <= 1'b0;
		else if (pipe_ack_o)
			pipe_stb_o <= pipe_stb_i && !keyed; // keyed pixels are transparent
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i && pipe_ack_o) begin
			dadr_o        <= dadr_i;
			color_o.rgb.r <= r_prod[BRIGHT_W +: 5];
			color_o.rgb.g <= g_prod[BRIGHT_W +: 6];
			color_o.rgb.b <= b_prod[BRIGHT_W +: 5];
		end
	end

endmodule

//--- logic/tmu_adrgen.sv
// destination pixel address generator

module tmu_adrgen import tmu_pkg::*; (
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  logic                 pipe_stb_i,
	output logic                 pipe_ack_o,
	input  logic [RES_W-1:0]     x_i,
	input  logic [RES_W-1:0]     y_i,
	input  pixel_t               color_i,
	input  logic [PIX_ADR_W-1:0] dst_fbuf_i,
	input  logic [RES_W-1:0]     dst_hres_i,
	output logic                 pipe_stb_o,
	input  logic                 pipe_ack_i,
	output logic [PIX_ADR_W-1:0] dadr_o,
	output pixel_t               color_o,
	output logic                 busy_o
);

	logic [2*RES_W-1:0] row_ofs;

	assign row_ofs    = y_i * dst_hres_i;
	assign pipe_ack_o = !pipe_stb_o || pipe_ack_i;
	assign busy_o     = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pipe_stb_o <= 1'b0;
		else if (pipe_ack_o)
			pipe_stb_o <= pipe_stb_i;
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i && pipe_ack_o) begin
			dadr_o  <= dst_fbuf_i + PIX_ADR_W'(row_ofs) + PIX_ADR_W'(x_i); // in 16-bit units
			color_o <= color_i;
		end
	end

endmodule

//--- logic/tmu_clamp.sv
// offset addition and off-screen filter

module tmu_clamp import tmu_pkg::*; (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  logic                      pipe_stb_i,
	output logic                      pipe_ack_o,
	input  logic signed [COORD_W-1:0] x_i,
	input  logic signed [COORD_W-1:0] y_i,
	input  pixel_t                    color_i,
	input  logic signed [COORD_W-1:0] dst_hoffset_i,
	input  logic signed [COORD_W-1:0] dst_voffset_i,
	input  logic [RES_W-1:0]          dst_hres_i,
	input  logic [RES_W-1:0]          dst_vres_i,
	output logic                      pipe_stb_o,
	input  logic                      pipe_ack_i,
	output logic [RES_W-1:0]          x_o,
	output logic [RES_W-1:0]          y_o,
	output pixel_t                    color_o,
	output logic                      busy_o
);

	logic signed [COORD_W:0] x_sum; // one extra bit so the sum cannot wrap
	logic signed [COORD_W:0] y_sum;
	logic                    visible;

	assign x_sum = x_i + dst_hoffset_i;
	assign y_sum = y_i + dst_voffset_i;

	// a negative sum has its top bit set and fails right away
	assign visible = !x_sum[COORD_W] && (x_sum[COORD_W-1:0] < {1'b0, dst_hres_i})
		&& !y_sum[COORD_W] && (y_sum[COORD_W-1:0] < {1'b0, dst_vres_i});

	assign pipe_ack_o = !pipe_stb_o || pipe_ack_i;
	assign busy_o     = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pipe_stb_o <= 1'b0;
		else if (pipe_ack_o)
			pipe_stb_o <= pipe_stb_i && visible; // off-screen points vanish here
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i && pipe_ack_o) begin
			x_o     <= x_sum[RES_W-1:0];
			y_o     <= y_sum[RES_W-1:0];
			color_o <= color_i;
		end
	end

endmodule

//--- control/tmu_ctlif.sv
// texture mapping unit register file and run control

module tmu_ctlif import tmu_pkg::*; (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  logic [3:0]                csr_a_i,
	input  logic                      csr_we_i,
	input  logic [31:0]               csr_di_i,
	output logic [31:0]               csr_do_o,
	output logic                      irq_o,
	input  logic                      frag_stb_i,
	input  logic                      frag_last_i,
	output logic                      frag_ack_o,
	output logic                      pipe_stb_o,
	input  logic                      pipe_ack_i,
	input  logic                      clamp_busy_i,
	input  logic                      adrgen_busy_i,
	input  logic                      decay_busy_i,
	input  logic                      burst_busy_i,
	input  logic                      pixout_busy_i,
	output logic                      flush_o,
	output logic [BRIGHT_W-1:0]       brightness_o,
	output logic                      chroma_key_en_o,
	output pixel_t                    chroma_key_o,
	output logic [PIX_ADR_W-1:0]      dst_fbuf_o,
	output logic [RES_W-1:0]          dst_hres_o,
	output logic [RES_W-1:0]          dst_vres_o,
	output logic signed [COORD_W-1:0] dst_hoffset_o,
	output logic signed [COORD_W-1:0] dst_voffset_o
);

	logic [2:0] state;
	logic       busy;
	logic       ctrl_wr;
	logic       start;
	logic       last_xfer;
	logic       front_busy;
	logic       any_busy;

	assign busy       = state != ST_IDLE;
	assign ctrl_wr    = csr_we_i & (csr_a_i == CSR_CTRL);
	assign start      = ctrl_wr & csr_di_i[0];
	assign front_busy = clamp_busy_i | adrgen_busy_i | decay_busy_i; // all pixels reached burst
	assign any_busy   = front_busy | burst_busy_i | pixout_busy_i;

	// fragments only pass while a run is active
	assign pipe_stb_o = frag_stb_i & (state == ST_RUN);
	assign frag_ack_o = pipe_ack_i & (state == ST_RUN);
	assign last_xfer  = pipe_stb_o & frag_ack_o & frag_last_i;
	assign flush_o    = state == ST_FLUSH;

	// ========================================
	// registers and sequencing
	// ========================================
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state           <= ST_IDLE;
			irq_o           <= 1'b0;
			brightness_o    <= '1;
			chroma_key_en_o <= 1'b0;
			chroma_key_o    <= '0;
			dst_fbuf_o      <= '0;
			dst_hres_o      <= '0;
			dst_vres_o      <= '0;
			dst_hoffset_o   <= '0;
			dst_voffset_o   <= '0;
		end else begin
			if (csr_we_i) begin
				case (csr_a_i)
					CSR_CTRL:   chroma_key_en_o <= csr_di_i[1];
					CSR_BRIGHT: brightness_o    <= csr_di_i[BRIGHT_W-1:0];
					CSR_KEY:    chroma_key_o    <= csr_di_i[15:0];
					CSR_FBUF:   dst_fbuf_o      <= csr_di_i[PIX_ADR_W-1:0];
					CSR_HRES:   dst_hres_o      <= csr_di_i[RES_W-1:0];
					CSR_VRES:   dst_vres_o      <= csr_di_i[RES_W-1:0];
					CSR_HOFS:   dst_hoffset_o   <= csr_di_i[COORD_W-1:0];
					CSR_VOFS:   dst_voffset_o   <= csr_di_i[COORD_W-1:0];
					default: ;
				endcase
			end
			if (ctrl_wr)
				irq_o <= 1'b0; // any write to CTRL acknowledges the interrupt
			case (state)
				ST_IDLE:         if (start) state <= ST_RUN;
				ST_RUN:          if (last_xfer) state <= ST_WAIT_PROCESS;
				ST_WAIT_PROCESS: if (!front_busy) state <= ST_FLUSH;
				ST_FLUSH:        state <= ST_WAIT_FLUSH;
				ST_WAIT_FLUSH: begin
					if (!any_busy) begin
						state <= ST_IDLE;
						irq_o <= 1'b1;
					end
				end
				default:         state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			csr_do_o <= '0;
		else begin
			case (csr_a_i)
				CSR_CTRL:   csr_do_o <= {29'd0, irq_o, chroma_key_en_o, busy};
				CSR_BRIGHT: csr_do_o <= 32'(brightness_o);
				CSR_KEY:    csr_do_o <= 32'(chroma_key_o.raw);
				CSR_FBUF:   csr_do_o <= 32'(dst_fbuf_o);
				CSR_HRES:   csr_do_o <= 32'(dst_hres_o);
				CSR_VRES:   csr_do_o <= 32'(dst_vres_o);
				CSR_HOFS:   csr_do_o <= 32'(dst_hoffset_o); // sign extended
				CSR_VOFS:   csr_do_o <= 32'(dst_voffset_o);
				default:    csr_do_o <= '0;
			endcase
		end
	end

	// the flush pulse only comes once every pixel has reached the burst stage
	a_flush_drained: assert property (@(posedge sys_clk) disable iff (sys_rst)
		flush_o |-> !front_busy)
		else $error("flush while pixels are still ahead of the burst stage");

endmodule

//--- common/tmu_pkg.sv
// texture mapping unit shared definitions

package tmu_pkg;

	// ========================================
	// widths
	// ========================================
	localparam int MEM_ADR_W    = 26;            // byte address of the write port
	localparam int PIX_ADR_W    = MEM_ADR_W - 1; // 16-bit pixel address
	localparam int WORD_ADR_W   = 23;            // 64-bit word address
	localparam int COORD_W      = 12;            // signed screen coordinate
	localparam int RES_W        = 11;
	localparam int BRIGHT_W     = 6;             // 63 leaves the color untouched
	localparam int PIX_PER_WORD = 4;
	localparam int LANE_W       = $clog2(PIX_PER_WORD);

	// ========================================
	// register word indices
	// ========================================
	localparam logic [3:0] CSR_CTRL   = 4'd0;
	localparam logic [3:0] CSR_BRIGHT = 4'd1;
	localparam logic [3:0] CSR_KEY    = 4'd2;
	localparam logic [3:0] CSR_FBUF   = 4'd3;
	localparam logic [3:0] CSR_HRES   = 4'd4;
	localparam logic [3:0] CSR_VRES   = 4'd5;
	localparam logic [3:0] CSR_HOFS   = 4'd6;
	localparam logic [3:0] CSR_VOFS   = 4'd7;

	// run sequencing states
	localparam logic [2:0] ST_IDLE         = 3'd0;
	localparam logic [2:0] ST_RUN          = 3'd1;
	localparam logic [2:0] ST_WAIT_PROCESS = 3'd2;
	localparam logic [2:0] ST_FLUSH        = 3'd3;
	localparam logic [2:0] ST_WAIT_FLUSH   = 3'd4;

	// RGB565 pixel, compared and packed as a word, scaled per field
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [4:0] r;
			logic [5:0] g;
			logic [4:0] b;
		} rgb;
	} pixel_t;

endpackage
